/* rtl/i2c_cfg.svh */
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// Bus bit timing in i2c_clk cycles
// SCL is low in the first half of the bit and high in the second half
`define I2C_PHASES_PER_BIT 4

// Data bits per bus byte, the acknowledge bit comes on top
`define I2C_BYTE_BITS 8

`endif

/* rtl/i2c_pkg.sv */
`include "i2c_cfg.svh"

package i2c_pkg;

    // One bus byte: address with R/W flag, write data or read data
    typedef logic [`I2C_BYTE_BITS-1:0] i2c_byte_t;

    // Bus step ordered by decode, carried out by the bit engine
    typedef enum logic [2:0] {
        STEP_NONE  = 3'd0,  // Nothing in progress
        STEP_START = 3'd1,  // Start or repeated start
        STEP_WRITE = 3'd2,  // Eight bits out, ACK in
        STEP_READ  = 3'd3,  // Eight bits in, ACK out
        STEP_STOP  = 3'd4   // Stop condition
    } i2c_step_e;

endpackage

/* rtl/i2c_cmd_decode.sv */
`timescale 1ns/1ps

module i2c_cmd_decode (
    input  logic               i2c_clk,
    input  logic               rst_n,
    input  logic               enable_i,
    input  i2c_pkg::i2c_byte_t slave_address_i,
    input  i2c_pkg::i2c_byte_t data_i,
    input  logic               repeated_start_i,
    input  logic               step_done_i,
    input  logic               ack_i,
    output i2c_pkg::i2c_step_e step_o,
    output i2c_pkg::i2c_byte_t tx_byte_o,
    output logic               step_valid_o,
    output logic               master_ack_o,
    output logic               data_req_o,
    output logic               busy_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,   // Start and address byte
        ST_WRITE,
        ST_READ,
        ST_STOP
    } txn_state_e;

    txn_state_e state;
    logic       rw_q;       // Bit 0 of the address, 1 = read
    logic       in_flight;  // Step ordered, engine not finished yet

    assign busy_o = (state != ST_IDLE);

    // NACK the byte that ends the read or comes before a restart
    assign master_ack_o = !enable_i || repeated_start_i;

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            step_o       <= i2c_pkg::STEP_NONE;
            tx_byte_o    <= '0;
            step_valid_o <= 1'b0;
            data_req_o   <= 1'b0;
            rw_q         <= 1'b0;
            in_flight    <= 1'b0;
        end else begin
            step_valid_o <= 1'b0;
            data_req_o   <= 1'b0;
            if (step_valid_o) begin
                in_flight <= 1'b1;
            end else if (step_done_i) begin
                in_flight <= 1'b0;
            end

            if (state == ST_IDLE) begin
                if (enable_i) begin
                    step_o       <= i2c_pkg::STEP_START;
                    step_valid_o <= 1'b1;
                    tx_byte_o    <= slave_address_i;  // Address held for the next step
                    rw_q         <= slave_address_i[0];
                    state        <= ST_ADDR;
                end
            end else if (step_done_i && in_flight) begin
                step_valid_o <= 1'b1;
                case (step_o)
                    i2c_pkg::STEP_START: begin
                        step_o <= i2c_pkg::STEP_WRITE;  // Send the latched address
                    end
                    i2c_pkg::STEP_WRITE: begin
                        if (ack_i || !enable_i) begin
                            step_o <= i2c_pkg::STEP_STOP;   // NACK or host done
                            state  <= ST_STOP;
                        end else if (state == ST_ADDR && rw_q) begin
                            step_o <= i2c_pkg::STEP_READ;
                            state  <= ST_READ;
                        end else if (state == ST_WRITE && repeated_start_i) begin
                            step_o    <= i2c_pkg::STEP_START;
                            tx_byte_o <= slave_address_i;
                            rw_q      <= slave_address_i[0];
                            state     <= ST_ADDR;
                        end else begin
                            step_o     <= i2c_pkg::STEP_WRITE;
                            tx_byte_o  <= data_i;
                            data_req_o <= 1'b1;   // Host may move to the next byte
                            state      <= ST_WRITE;
                        end
                    end
                    i2c_pkg::STEP_READ: begin
                        if (!ack_i) begin
                            step_o <= i2c_pkg::STEP_READ;   // We ACKed, slave goes on
                        end else if (enable_i && repeated_start_i) begin
                            step_o    <= i2c_pkg::STEP_START;
                            tx_byte_o <= slave_address_i;
                            rw_q      <= slave_address_i[0];
                            state     <= ST_ADDR;
                        end else begin
                            step_o <= i2c_pkg::STEP_STOP;
                            state  <= ST_STOP;
                        end
                    end
                    default: begin
                        // Stop finished, bus is free again
                        step_o       <= i2c_pkg::STEP_NONE;
                        step_valid_o <= 1'b0;
                        state        <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // One step on the bus at a time
    a_one_step: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        step_valid_o |-> !in_flight);

endmodule

/* rtl/i2c_bit_engine.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module i2c_bit_engine (
    input  logic               i2c_clk,
    input  logic               rst_n,
    input  i2c_pkg::i2c_step_e step_i,
    input  i2c_pkg::i2c_byte_t tx_byte_i,
    input  logic               step_valid_i,
    input  logic               master_ack_i,
    input  logic               sda_i,
    output logic               step_done_o,
    output logic               ack_o,
    output logic               rx_bit_o,
    output logic               rx_bit_valid_o,
    output logic               byte_end_o,
    output logic               nack_seen_o,
    output logic               stop_done_o,
    output logic               scl_o,
    output logic               sda_o
);

    localparam int PH_W    = $clog2(`I2C_PHASES_PER_BIT);
    localparam int PH_LAST = `I2C_PHASES_PER_BIT - 1;
    localparam int PH_HIGH = `I2C_PHASES_PER_BIT / 2;  // First phase with SCL high
    localparam int BIT_W   = $clog2(`I2C_BYTE_BITS + 1);

    i2c_pkg::i2c_step_e cur_step;
    i2c_pkg::i2c_byte_t tx_shift;
    logic [PH_W-1:0]    phase_q;
    logic [BIT_W-1:0]   bit_q;     // 0..7 data, 8 = acknowledge bit
    logic               active_q;
    logic               in_txn_q;  // Bus owned between start and stop
    logic               sda_q;
    logic               ack_q;
    logic               byte_step;
    logic               ack_bit;

    assign byte_step = (cur_step == i2c_pkg::STEP_WRITE) || (cur_step == i2c_pkg::STEP_READ);
    assign ack_bit   = (bit_q == BIT_W'(`I2C_BYTE_BITS));

    assign step_done_o = active_q && (phase_q == PH_W'(PH_LAST)) && (!byte_step || ack_bit);

    assign ack_o          = ack_q;
    assign rx_bit_o       = sda_i;
    assign rx_bit_valid_o = active_q && (cur_step == i2c_pkg::STEP_READ)
                            && (phase_q == PH_W'(PH_HIGH)) && !ack_bit;
    assign byte_end_o     = step_done_o && (cur_step == i2c_pkg::STEP_READ);
    assign nack_seen_o    = step_done_o && (cur_step == i2c_pkg::STEP_WRITE) && ack_q;
    assign stop_done_o    = step_done_o && (cur_step == i2c_pkg::STEP_STOP);
    assign sda_o          = sda_q;

    always_comb begin
        if (!active_q) begin
            scl_o = 1'b1;
        end else if (cur_step == i2c_pkg::STEP_START && !in_txn_q) begin
            scl_o = 1'b1;  // First start needs no low SCL half
        end else begin
            scl_o = (phase_q >= PH_W'(PH_HIGH));
        end
    end

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_step <= i2c_pkg::STEP_NONE;
            phase_q  <= '0;
            bit_q    <= '0;
            active_q <= 1'b0;
            in_txn_q <= 1'b0;
            sda_q    <= 1'b1;
            ack_q    <= 1'b1;
        end else if (step_valid_i) begin
            cur_step <= step_i;
            phase_q  <= '0;
            bit_q    <= '0;
            active_q <= 1'b1;
        end else if (active_q) begin
            phase_q <= phase_q + 1'b1;

            // SDA moves one cycle after SCL fell
            if (phase_q == '0) begin
                case (cur_step)
                    i2c_pkg::STEP_START: sda_q <= 1'b1;
                    i2c_pkg::STEP_STOP:  sda_q <= 1'b0;
                    i2c_pkg::STEP_WRITE: sda_q <= ack_bit ? 1'b1 : tx_shift[`I2C_BYTE_BITS-1];
                    i2c_pkg::STEP_READ:  sda_q <= ack_bit ? master_ack_i : 1'b1;
                    default:             sda_q <= 1'b1;
                endcase
            end

            if (phase_q == PH_W'(PH_HIGH)) begin
                if (cur_step == i2c_pkg::STEP_START) begin
                    sda_q <= 1'b0;  // Start: SDA falls under high SCL
                end
                if (cur_step == i2c_pkg::STEP_STOP) begin
                    sda_q <= 1'b1;  // Stop: SDA rises under high SCL
                end
                if (byte_step && ack_bit) begin
                    ack_q <= sda_i;
                end
            end

            if (phase_q == PH_W'(PH_LAST)) begin
                phase_q <= '0;
                if (step_done_o) begin
                    active_q <= 1'b0;
                    if (cur_step == i2c_pkg::STEP_START) begin
                        in_txn_q <= 1'b1;
                    end
                    if (cur_step == i2c_pkg::STEP_STOP) begin
                        in_txn_q <= 1'b0;
                    end
                end else begin
                    bit_q <= bit_q + 1'b1;
                end
            end
        end
    end

    // Write byte, MSB first
    always_ff @(posedge i2c_clk) begin
        if (step_valid_i) begin
            tx_shift <= tx_byte_i;
        end else if (active_q && cur_step == i2c_pkg::STEP_WRITE && phase_q == '0 && !ack_bit) begin
            tx_shift <= tx_shift << 1;
        end
    end

    // Inside a byte, data may only move while SCL is low
    a_sda_scl_low: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        (active_q && byte_step && $changed(sda_q)) |-> (!scl_o && !$past(scl_o)));

    a_bit_range: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        bit_q <= BIT_W'(`I2C_BYTE_BITS));

endmodule

/* rtl/i2c_rx_result.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module i2c_rx_result (
    input  logic               i2c_clk,
    input  logic               rst_n,
    input  logic               rx_bit_i,
    input  logic               rx_bit_valid_i,
    input  logic               byte_end_i,
    input  logic               nack_seen_i,
    input  logic               stop_done_i,
    output i2c_pkg::i2c_byte_t rx_data_o,
    output logic               rx_valid_o,
    output logic               nack_o,
    output logic               done_o
);

    localparam int CNT_W = $clog2(`I2C_BYTE_BITS + 1);

    i2c_pkg::i2c_byte_t rx_shift;
    logic [CNT_W-1:0]   bit_cnt;  // Read bits seen in the current byte

    // Bits arrive MSB first
    always_ff @(posedge i2c_clk) begin
        if (rx_bit_valid_i) begin
            rx_shift <= {rx_shift[`I2C_BYTE_BITS-2:0], rx_bit_i};
        end
        if (byte_end_i) begin
            rx_data_o <= rx_shift;
        end
    end

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid_o <= 1'b0;
            nack_o     <= 1'b0;
            done_o     <= 1'b0;
            bit_cnt    <= '0;
        end else begin
            rx_valid_o <= byte_end_i;   // Same cycle rx_data_o updates
            nack_o     <= nack_seen_i;
            done_o     <= stop_done_i;
            if (byte_end_i) begin
                bit_cnt <= '0;
            end else if (rx_bit_valid_i) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // A read byte closes only after all of its data bits
    a_full_byte: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        byte_end_i |-> (bit_cnt == CNT_W'(`I2C_BYTE_BITS)));

endmodule

/* rtl/i2c_master_top.sv */
`timescale 1ns/1ps

module i2c_master_top (
    input  logic               i2c_clk,
    input  logic               rst_n,
    input  logic               enable_i,
    input  i2c_pkg::i2c_byte_t slave_address_i,
    input  i2c_pkg::i2c_byte_t data_i,
    input  logic               repeated_start_i,
    input  logic               sda_i,
    output logic               scl_o,
    output logic               sda_o,
    output logic               busy_o,
    output logic               data_req_o,
    output i2c_pkg::i2c_byte_t rx_data_o,
    output logic               rx_valid_o,
    output logic               nack_o,
    output logic               done_o
);

    i2c_pkg::i2c_step_e step;
    i2c_pkg::i2c_byte_t tx_byte;
    logic               step_valid;
    logic               master_ack;
    logic               step_done;
    logic               ack;
    logic               rx_bit;
    logic               rx_bit_valid;
    logic               byte_end;
    logic               nack_seen;
    logic               stop_done;

    i2c_cmd_decode u_decode (
        .i2c_clk          (i2c_clk),
        .rst_n            (rst_n),
        .enable_i         (enable_i),
        .slave_address_i  (slave_address_i),
        .data_i           (data_i),
        .repeated_start_i (repeated_start_i),
        .step_done_i      (step_done),
        .ack_i            (ack),
        .step_o           (step),
        .tx_byte_o        (tx_byte),
        .step_valid_o     (step_valid),
        .master_ack_o     (master_ack),
        .data_req_o       (data_req_o),
        .busy_o           (busy_o)
    );

    i2c_bit_engine u_engine (
        .i2c_clk        (i2c_clk),
        .rst_n          (rst_n),
        .step_i         (step),
        .tx_byte_i      (tx_byte),
        .step_valid_i   (step_valid),
        .master_ack_i   (master_ack),
        .sda_i          (sda_i),
        .step_done_o    (step_done),
        .ack_o          (ack),
        .rx_bit_o       (rx_bit),
        .rx_bit_valid_o (rx_bit_valid),
        .byte_end_o     (byte_end),
        .nack_seen_o    (nack_seen),
        .stop_done_o    (stop_done),
        .scl_o          (scl_o),
        .sda_o          (sda_o)
    );

    i2c_rx_result u_result (
        .i2c_clk        (i2c_clk),
        .rst_n          (rst_n),
        .rx_bit_i       (rx_bit),
        .rx_bit_valid_i (rx_bit_valid),
        .byte_end_i     (byte_end),
        .nack_seen_i    (nack_seen),
        .stop_done_i    (stop_done),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .nack_o         (nack_o),
        .done_o         (done_o)
    );

endmodule

/* tests/i2c_target_model.sv */
`timescale 1ns/1ps

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  logic               rst_n,
    input  logic               scl_i,
    input  logic               sda_i,
    output logic               sda_drive_o,      // 0 pulls the bus low
    output i2c_pkg::i2c_byte_t wr_data_o,
    output int                 wr_count_o,
    output int                 start_count_o,
    output int                 stop_count_o,
    output int                 restart_count_o,  // Starts with no stop before them
    output logic               mack_o,           // Master acknowledge of the last read byte
    output int                 mack_count_o
);

    typedef enum {T_IDLE, T_ADDR, T_WDATA, T_RDATA} tgt_state_e;

    tgt_state_e         state;
    i2c_pkg::i2c_byte_t shift;
    i2c_pkg::i2c_byte_t rd_byte;
    int                 bit_cnt;   // 8 = data done, 9 = acknowledge done
    int                 rd_k;
    logic               rw;
    logic               in_txn;
    logic               prev_scl;
    logic               prev_sda;

    // Idle state with the bus released
    task automatic clear_state();
        state = T_IDLE;
        sda_drive_o = 1'b1;
        bit_cnt = 0;
        rd_k = 0;
        in_txn = 1'b0;
        mack_o = 1'b1;
        wr_data_o = '0;
        {wr_count_o, start_count_o, stop_count_o, restart_count_o, mack_count_o} = '0;
    endtask

    initial begin
        clear_state();
    end

    always @(posedge scl_i or negedge scl_i or posedge sda_i or negedge sda_i or negedge rst_n) begin
        if (rst_n !== 1'b1) begin
            clear_state();
        end else if (scl_i !== prev_scl && scl_i === 1'b1) begin
            if (state != T_IDLE) begin
                if (bit_cnt < 8) begin
                    shift = {shift[6:0], sda_i};
                end else if (state == T_RDATA) begin
                    mack_o = sda_i;
                    mack_count_o++;
                end
                bit_cnt++;
            end
        end else if (scl_i !== prev_scl && scl_i === 1'b0) begin
            if (state != T_IDLE && bit_cnt == 8) begin
                if (state == T_ADDR && shift[7:1] == ADDR) begin
                    sda_drive_o = 1'b0;
                    rw = shift[0];
                end else if (state == T_ADDR) begin
                    state = T_IDLE;  // Not our address
                end else if (state == T_WDATA) begin
                    wr_data_o = shift;
                    wr_count_o++;
                    sda_drive_o = 1'b0;
                end else begin
                    sda_drive_o = 1'b1;  // Master owns the acknowledge bit
                end
            end else if (state != T_IDLE && bit_cnt == 9) begin
                sda_drive_o = 1'b1;
                bit_cnt = 0;
                if (state == T_ADDR) begin
                    state = rw ? T_RDATA : T_WDATA;
                end else if (state == T_RDATA && mack_o) begin
                    state = T_IDLE;
                end
                if (state == T_RDATA) begin
                    rd_byte = 8'(8'hA5 + 3 * rd_k);
                    rd_k++;
                    sda_drive_o = rd_byte[7];
                end
            end else if (state == T_RDATA && bit_cnt >= 1 && bit_cnt <= 7) begin
                sda_drive_o = rd_byte[7-bit_cnt];
            end
        end else if (sda_i !== prev_sda && scl_i === 1'b1 && sda_i === 1'b0) begin
            if (in_txn) restart_count_o++;
            in_txn = 1'b1;
            start_count_o++;
            state = T_ADDR;
            bit_cnt = 0;
            rd_k = 0;
            sda_drive_o = 1'b1;
        end else if (sda_i !== prev_sda && scl_i === 1'b1 && sda_i === 1'b1) begin
            in_txn = 1'b0;
            stop_count_o++;
            state = T_IDLE;
            sda_drive_o = 1'b1;
        end
        prev_scl = scl_i;
        prev_sda = sda_i;
    end

endmodule

/* tests/i2c_checker.sv */
`timescale 1ns/1ps

module i2c_checker (
    input  logic               i2c_clk,
    input  logic               rst_n,
    input  i2c_pkg::i2c_byte_t data_i,
    input  logic               data_req_i,
    input  i2c_pkg::i2c_byte_t rx_data_i,
    input  logic               rx_valid_i,
    input  logic               nack_i,
    input  logic               done_i,
    input  logic               busy_i,
    input  logic               scl_i,
    input  logic               sda_i,
    input  i2c_pkg::i2c_byte_t wr_data_i,
    input  int                 wr_count_i,
    input  int                 start_count_i,
    input  int                 stop_count_i,
    input  int                 restart_count_i,
    input  logic               mack_i,
    input  int                 mack_count_i,
    input  logic               txn_end_i,
    input  int                 exp_writes_i,
    input  int                 exp_reads_i,
    input  int                 exp_nacks_i,
    input  int                 exp_restarts_i,
    output int                 error_count_o,
    output int                 check_count_o
);

    i2c_pkg::i2c_byte_t wr_expect[$];  // Bytes the DUT took from the host
    logic               mack_q[$];
    i2c_pkg::i2c_byte_t exp_byte;
    int wr_seen = 0;
    int starts_seen = 0;
    int stops_seen = 0;
    int mack_seen = 0;
    int restart_base = 0;
    int rd_k = 0;
    int n_wr = 0;
    int n_rd = 0;
    int n_nack = 0;
    int n_done = 0;

    initial begin
        error_count_o = 0;
        check_count_o = 0;
    end

    // Read byte k of a transaction
    function automatic i2c_pkg::i2c_byte_t expected_read(input int k);
        return 8'(8'hA5 + 3 * k);
    endfunction

    task automatic flag_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        error_count_o++;
    endtask

    task automatic check_equal(input int got, input int exp, input string what);
        check_count_o++;
        if (got != exp) flag_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    always @(posedge i2c_clk) begin
        if (rst_n) begin
            if (start_count_i != starts_seen) begin
                starts_seen = start_count_i;
                rd_k = 0;  // Read numbering restarts with every start
            end
            if (data_req_i) wr_expect.push_back(data_i);
            if (wr_count_i != wr_seen) begin
                wr_seen = wr_count_i;
                n_wr++;
                if (wr_expect.size() == 0) begin
                    flag_error($sformatf("target got byte %02h the host never gave", wr_data_i));
                end else begin
                    exp_byte = wr_expect.pop_front();
                    check_equal(int'(wr_data_i), int'(exp_byte), "byte written to target");
                end
            end
            if (rx_valid_i) begin
                check_equal(int'(rx_data_i), int'(expected_read(rd_k)), "read byte");
                rd_k++;
                n_rd++;
            end
            if (mack_count_i != mack_seen) begin
                mack_seen = mack_count_i;
                mack_q.push_back(mack_i);
            end
            if (stop_count_i != stops_seen) begin
                stops_seen = stop_count_i;
                // ACK on every read byte, NACK on the last
                for (int i = 0; i < mack_q.size(); i++) begin
                    check_equal(int'(mack_q[i]), (i == mack_q.size() - 1) ? 1 : 0,
                                "master acknowledge bit");
                end
                mack_q.delete();
            end
            if (nack_i) n_nack++;
            if (done_i) begin
                n_done++;
                if (busy_i) flag_error("busy_o still high with done_o");
            end
            if (!busy_i && (scl_i !== 1'b1 || sda_i !== 1'b1)) begin
                flag_error("bus not released while the master is idle");
            end
            if (txn_end_i) begin
                check_equal(n_wr, exp_writes_i, "write byte count");
                check_equal(wr_expect.size(), 0, "bytes taken but not seen by target");
                check_equal(n_rd, exp_reads_i, "read byte count");
                check_equal(n_nack, exp_nacks_i, "nack_o count");
                check_equal(n_done, 1, "done_o count");
                check_equal(restart_count_i - restart_base, exp_restarts_i, "repeated starts");
                check_equal(int'(busy_i), 0, "busy_o between transactions");
                restart_base = restart_count_i;
                wr_expect.delete();
                {n_wr, n_rd, n_nack, n_done} = '0;
            end
        end
    end

endmodule

/* tests/tb_i2c_master.sv */
`timescale 1ns/1ps

module tb_i2c_master;

    localparam logic [6:0] TARGET_ADDR = 7'h50;
    localparam logic [6:0] ABSENT_ADDR = 7'h3c;

    logic               i2c_clk;
    logic               rst_n;
    logic               enable;
    logic               repeated_start;
    i2c_pkg::i2c_byte_t slave_address;
    i2c_pkg::i2c_byte_t data;
    i2c_pkg::i2c_byte_t rx_data;
    i2c_pkg::i2c_byte_t wr_data;
    logic               scl, sda_m, sda_t, sda_bus;
    logic               busy, data_req, rx_valid, nack, done, mack, txn_end;
    int                 wr_count, start_count, stop_count, restart_count, mack_count;
    int                 exp_writes, exp_reads, exp_nacks, exp_restarts;
    int                 error_count, check_count;
    logic [31:0]        rng_state;
    int                 cycles = 0;
    int                 cycle_limit;
    int                 n_write, n_read, k_write, m_read;

    assign sda_bus = sda_m & sda_t;  // Open drain wired-AND

    always #5 i2c_clk = ~i2c_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic i2c_pkg::i2c_byte_t rand_byte();
        return 8'(next_rand());
    endfunction

    i2c_master_top i_dut (
        .i2c_clk(i2c_clk), .rst_n(rst_n), .enable_i(enable),
        .slave_address_i(slave_address), .data_i(data), .repeated_start_i(repeated_start),
        .sda_i(sda_bus), .scl_o(scl), .sda_o(sda_m), .busy_o(busy), .data_req_o(data_req),
        .rx_data_o(rx_data), .rx_valid_o(rx_valid), .nack_o(nack), .done_o(done)
    );

    i2c_target_model #(.ADDR(TARGET_ADDR)) i_target (
        .rst_n(rst_n), .scl_i(scl), .sda_i(sda_bus), .sda_drive_o(sda_t),
        .wr_data_o(wr_data), .wr_count_o(wr_count), .start_count_o(start_count),
        .stop_count_o(stop_count), .restart_count_o(restart_count),
        .mack_o(mack), .mack_count_o(mack_count)
    );

    i2c_checker i_checker (
        .i2c_clk(i2c_clk), .rst_n(rst_n), .data_i(data), .data_req_i(data_req),
        .rx_data_i(rx_data), .rx_valid_i(rx_valid), .nack_i(nack), .done_i(done),
        .busy_i(busy), .scl_i(scl), .sda_i(sda_m), .wr_data_i(wr_data),
        .wr_count_i(wr_count), .start_count_i(start_count), .stop_count_i(stop_count),
        .restart_count_i(restart_count), .mack_i(mack), .mack_count_i(mack_count),
        .txn_end_i(txn_end), .exp_writes_i(exp_writes), .exp_reads_i(exp_reads),
        .exp_nacks_i(exp_nacks), .exp_restarts_i(exp_restarts),
        .error_count_o(error_count), .check_count_o(check_count)
    );

    always @(posedge i2c_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a transaction never finished", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic wait_done();
        @(posedge i2c_clk);
        while (!done) @(posedge i2c_clk);
    endtask

    // Hand the expected totals of one transaction to the checker
    task automatic close_txn(input int w, input int r, input int n, input int rs);
        repeat (4) @(posedge i2c_clk);
        exp_writes <= w;
        exp_reads <= r;
        exp_nacks <= n;
        exp_restarts <= rs;
        txn_end <= 1'b1;
        @(posedge i2c_clk);
        txn_end <= 1'b0;
        repeat (4) @(posedge i2c_clk);
    endtask

    // Write n bytes, optionally asking for a restart read after the last one
    task automatic write_bytes(input int n, input logic restart);
        int taken;
        taken = 0;
        slave_address <= {TARGET_ADDR, 1'b0};
        data <= rand_byte();
        enable <= 1'b1;
        while (taken < n) begin
            @(posedge i2c_clk);
            if (data_req) begin
                taken++;
                if (taken < n) begin
                    data <= rand_byte();
                end else if (restart) begin
                    repeated_start <= 1'b1;
                    slave_address <= {TARGET_ADDR, 1'b1};
                end else begin
                    enable <= 1'b0;
                end
            end
        end
    endtask

    // Drop enable after n-1 bytes so the last one gets a NACK
    task automatic read_bytes(input int n);
        int got;
        got = 0;
        enable <= 1'b1;
        while (got < n) begin
            @(posedge i2c_clk);
            if (rx_valid) begin
                got++;
                if (got == n - 1) enable <= 1'b0;
            end
        end
    endtask

    task automatic run_absent_write();
        slave_address <= {ABSENT_ADDR, 1'b0};
        enable <= 1'b1;
        @(posedge i2c_clk);
        while (!nack) @(posedge i2c_clk);
        enable <= 1'b0;
        wait_done();
    endtask

    task automatic run_restart_read(input int k, input int m);
        int start_base;
        start_base = start_count;
        write_bytes(k, 1'b1);
        while (start_count < start_base + 2) @(posedge i2c_clk);
        repeated_start <= 1'b0;  // Second start seen on the bus
        read_bytes(m);
        wait_done();
    endtask

    initial begin
        i2c_clk = 1'b0;
        rst_n = 1'b0;
        enable = 1'b0;
        repeated_start = 1'b0;
        slave_address = '0;
        data = '0;
        txn_end = 1'b0;
        {exp_writes, exp_reads, exp_nacks, exp_restarts} = '0;
        rng_state = 32'h9c19;
        n_write = 1 + int'(next_rand() % 32'd6);
        n_read = 2 + int'(next_rand() % 32'd4);
        k_write = 1 + int'(next_rand() % 32'd3);
        m_read = 2 + int'(next_rand() % 32'd3);
        cycle_limit = ((n_write + 2) + (n_read + 2) + 2 + (k_write + m_read + 3)) * 40 + 400;
        repeat (2) @(posedge i2c_clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge i2c_clk);

        write_bytes(n_write, 1'b0);
        wait_done();
        close_txn(n_write, 0, 0, 0);
        slave_address <= {TARGET_ADDR, 1'b1};
        read_bytes(n_read);
        wait_done();
        close_txn(0, n_read, 0, 0);
        run_absent_write();
        close_txn(0, 0, 1, 0);
        run_restart_read(k_write, m_read);
        close_txn(k_write, m_read, 0, 1);

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/i2c_pkg.sv
rtl/i2c_cmd_decode.sv
rtl/i2c_bit_engine.sv
rtl/i2c_rx_result.sv
rtl/i2c_master_top.sv
tests/i2c_target_model.sv
tests/i2c_checker.sv
tests/tb_i2c_master.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_i2c_master
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
